// ==== Makefile ====
# Verilator build and run of the APB bridge testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = apb_bridge_tb
FILELIST  = apb_bridge.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== apb_bridge.f ====
design/apb_bridge_pkg.sv
design/wb_apb_master.sv
design/apb_decoder.sv
design/apb_reg_slave.sv
design/apb_read_mux.sv
design/apb_bridge_top.sv
verification/apb_bridge_tb.sv

// ==== design/apb_bridge_pkg.sv ====
// --------------------------------------------------
// APB bridge package
// Widths, address map, bus timer limit and the
// master state encoding shared by the subsystem
// --------------------------------------------------

package apb_bridge_pkg;

   // Byte address on both the Wishbone and the APB side
   typedef logic [31:0] addr_t;

   // One full data word, all transfers are 32 bits wide
   typedef logic [31:0] data_t;

   // Wait-state count held in each register slave
   typedef logic [7:0] wait_t;

   // Slave index field and register offset field of an address
   typedef logic [3:0] slave_idx_t;
   typedef logic [1:0] reg_idx_t;

   // Access-phase cycle counter of the master
   typedef logic [7:0] timer_t;

   // Number of register slaves behind the decoder
   localparam int NUM_SLAVES = 4;

   // Address map: bits 11:8 pick the slave, bits 3:2 pick the register
   localparam int SLAVE_IDX_LSB = 8;
   localparam int REG_IDX_LSB = 2;

   // Register offsets inside a slave
   localparam reg_idx_t REG_WAIT = 2'd0;
   localparam reg_idx_t REG_SCRATCH_FIRST = 2'd1;
   localparam reg_idx_t REG_SCRATCH_LAST = 2'd3;

   // Access cycles without pready before the master gives up
   localparam timer_t BUS_TIMEOUT = 8'd100;

   // Bridge master FSM states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SETUP,
      ST_ACCESS,
      ST_DONE
   } master_state_t;

endpackage

// ==== design/apb_bridge_top.sv ====
// --------------------------------------------------
// APB register subsystem top level
// Wishbone host port, bridge master, decoder, slave
// row and read-back multiplexer
// --------------------------------------------------

`timescale 1ns/1ns

module apb_bridge_top
(
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  apb_bridge_pkg::addr_t wb_adr,
   input  apb_bridge_pkg::data_t wb_dat_w,
   output logic                  wb_ack,
   output logic                  wb_err,
   output apb_bridge_pkg::data_t wb_dat_r
);

   logic                                                    psel;
   logic                                                    penable;
   logic                                                    pwrite;
   apb_bridge_pkg::addr_t                                   paddr;
   apb_bridge_pkg::data_t                                   pwdata;
   apb_bridge_pkg::data_t                                   prdata;
   logic                                                    pready;
   logic                                                    pslverr;
   logic [apb_bridge_pkg::NUM_SLAVES-1:0]                   psel_vec;
   logic                                                    unmapped;
   apb_bridge_pkg::data_t [apb_bridge_pkg::NUM_SLAVES-1:0] slave_prdata;
   logic [apb_bridge_pkg::NUM_SLAVES-1:0]                   slave_pready;
   logic [apb_bridge_pkg::NUM_SLAVES-1:0]                   slave_pslverr;

   wb_apb_master master0 (
      .clk(clk), .reset_n(reset_n),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
      .wb_ack(wb_ack), .wb_err(wb_err), .wb_dat_r(wb_dat_r),
      .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr)
   );

   apb_decoder decoder0 (
      .psel(psel), .paddr(paddr),
      .psel_vec(psel_vec), .unmapped(unmapped)
   );

   // Every slave sees the shared APB request and its own select line
   for (genvar i = 0; i < apb_bridge_pkg::NUM_SLAVES; i++)
   begin : g_slave
      apb_reg_slave slave (
         .clk(clk), .reset_n(reset_n),
         .psel(psel_vec[i]), .penable(penable), .pwrite(pwrite),
         .paddr(paddr), .pwdata(pwdata),
         .prdata(slave_prdata[i]), .pready(slave_pready[i]),
         .pslverr(slave_pslverr[i])
      );
   end

   apb_read_mux read_mux0 (
      .psel_vec(psel_vec), .unmapped(unmapped),
      .slave_prdata(slave_prdata), .slave_pready(slave_pready),
      .slave_pslverr(slave_pslverr),
      .prdata(prdata), .pready(pready), .pslverr(pslverr)
   );

endmodule

// ==== design/apb_decoder.sv ====
// --------------------------------------------------
// APB address decoder
// One select line per register slave, plus a flag
// for addresses outside the slave row
// --------------------------------------------------

`timescale 1ns/1ns

module apb_decoder
(
   input  logic                                    psel,
   input  apb_bridge_pkg::addr_t                   paddr,
   output logic [apb_bridge_pkg::NUM_SLAVES-1:0] psel_vec,
   output logic                                    unmapped
);

   apb_bridge_pkg::slave_idx_t slave_idx;

   assign slave_idx =
      paddr[apb_bridge_pkg::SLAVE_IDX_LSB +: $bits(apb_bridge_pkg::slave_idx_t)];

   always_comb
   begin
      for (int i = 0; i < apb_bridge_pkg::NUM_SLAVES; i++)
      begin
         psel_vec[i] = psel && (slave_idx == apb_bridge_pkg::slave_idx_t'(i));
      end
   end

   // Indices 4 to 15 have no slave behind them
   assign unmapped = psel &&
      (slave_idx >= apb_bridge_pkg::slave_idx_t'(apb_bridge_pkg::NUM_SLAVES));

   // A selected access goes to exactly one slave or to the unmapped responder
   always_comb
   begin
      assert ($onehot0({psel_vec, unmapped}))
         else $error("more than one APB target selected");
      assert (!psel || $onehot({psel_vec, unmapped}))
         else $error("APB access without a target");
   end

endmodule

// ==== design/apb_read_mux.sv ====
// --------------------------------------------------
// APB read-back multiplexer
// Returns the response lanes of the selected slave
// and answers unmapped accesses with an error
// --------------------------------------------------

`timescale 1ns/1ns

module apb_read_mux
(
   input  logic [apb_bridge_pkg::NUM_SLAVES-1:0]                        psel_vec,
   input  logic                                                         unmapped,
   input  apb_bridge_pkg::data_t [apb_bridge_pkg::NUM_SLAVES-1:0]     slave_prdata,
   input  logic [apb_bridge_pkg::NUM_SLAVES-1:0]                        slave_pready,
   input  logic [apb_bridge_pkg::NUM_SLAVES-1:0]                        slave_pslverr,
   output apb_bridge_pkg::data_t                                        prdata,
   output logic                                                         pready,
   output logic                                                         pslverr
);

   always_comb
   begin
      prdata  = '0;
      pready  = 1'b0;
      pslverr = 1'b0;

      if (unmapped)
      begin
         // Nothing lives here, finish the access phase at once with an error
         pready  = 1'b1;
         pslverr = 1'b1;
      end
      else
      begin
         // The decoder selects at most one slave
         for (int i = 0; i < apb_bridge_pkg::NUM_SLAVES; i++)
         begin
            if (psel_vec[i])
            begin
               prdata  = slave_prdata[i];
               pready  = slave_pready[i];
               pslverr = slave_pslverr[i];
            end
         end
      end
   end

endmodule

// ==== design/apb_reg_slave.sv ====
// --------------------------------------------------
// APB register slave
// Wait-state register at offset 0 and three scratch
// words, with a programmable response delay
// --------------------------------------------------

`timescale 1ns/1ns

module apb_reg_slave
(
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  apb_bridge_pkg::addr_t paddr,
   input  apb_bridge_pkg::data_t pwdata,
   output apb_bridge_pkg::data_t prdata,
   output logic                  pready,
   output logic                  pslverr
);

   apb_bridge_pkg::reg_idx_t offset;
   apb_bridge_pkg::wait_t    wait_reg;
   apb_bridge_pkg::wait_t    wait_cnt;
   apb_bridge_pkg::data_t    scratch [apb_bridge_pkg::REG_SCRATCH_FIRST:
                                      apb_bridge_pkg::REG_SCRATCH_LAST];
   logic                     access;
   logic                     wait_done;

   assign offset =
      paddr[apb_bridge_pkg::REG_IDX_LSB +: $bits(apb_bridge_pkg::reg_idx_t)];
   assign access = psel && penable;

   // The wait register itself always answers at once, so a large count
   // can still be written back to a small one
   assign wait_done = (offset == apb_bridge_pkg::REG_WAIT) || (wait_cnt == wait_reg);
   assign pready    = access && wait_done;

   // The two offset bits address all four registers, no offset is out of range
   assign pslverr = 1'b0;

   // Counts access cycles, restarted by every setup phase
   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         wait_cnt <= '0;
      end
      else if (psel && !penable)
      begin
         wait_cnt <= '0;
      end
      else if (access && !wait_done)
      begin
         wait_cnt <= wait_cnt + 8'd1;
      end
   end

   // Writes take effect on the access cycle that completes the transfer
   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         wait_reg <= '0;
         for (int i = apb_bridge_pkg::REG_SCRATCH_FIRST;
              i <= apb_bridge_pkg::REG_SCRATCH_LAST; i++)
         begin
            scratch[i] <= '0;
         end
      end
      else if (pready && pwrite)
      begin
         if (offset == apb_bridge_pkg::REG_WAIT)
         begin
            // Only the low byte of the count is kept
            wait_reg <= pwdata[$bits(apb_bridge_pkg::wait_t)-1:0];
         end
         else
         begin
            scratch[offset] <= pwdata;
         end
      end
   end

   always_comb
   begin
      if (offset == apb_bridge_pkg::REG_WAIT)
      begin
         prdata = apb_bridge_pkg::data_t'(wait_reg);
      end
      else
      begin
         prdata = scratch[offset];
      end
   end

   // A response only comes for a request that was already selected, at the
   // same address, in the cycle before
   assert property (@(posedge clk) disable iff (!reset_n)
      pready |-> $past(psel) && $stable(paddr))
      else $error("pready outside the APB access phase");

endmodule

// ==== design/wb_apb_master.sv ====
// --------------------------------------------------
// Wishbone to APB bridge master
// Turns one Wishbone classic request into one APB
// transfer, guarded by a bus timer
// --------------------------------------------------

`timescale 1ns/1ns

module wb_apb_master
(
   input  logic                  clk,
   input  logic                  reset_n,

   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  apb_bridge_pkg::addr_t wb_adr,
   input  apb_bridge_pkg::data_t wb_dat_w,
   output logic                  wb_ack,
   output logic                  wb_err,
   output apb_bridge_pkg::data_t wb_dat_r,

   output logic                  psel,
   output logic                  penable,
   output logic                  pwrite,
   output apb_bridge_pkg::addr_t paddr,
   output apb_bridge_pkg::data_t pwdata,
   input  apb_bridge_pkg::data_t prdata,
   input  logic                  pready,
   input  logic                  pslverr
);

   apb_bridge_pkg::master_state_t state;
   apb_bridge_pkg::timer_t        bus_timer;

   // Control path: FSM, APB phase strobes, bus timer and the response
   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state     <= apb_bridge_pkg::ST_IDLE;
         psel      <= 1'b0;
         penable   <= 1'b0;
         bus_timer <= '0;
         wb_ack    <= 1'b0;
         wb_err    <= 1'b0;
      end
      else
      begin
         // Responses last for a single cycle
         wb_ack <= 1'b0;
         wb_err <= 1'b0;

         case (state)
            apb_bridge_pkg::ST_IDLE:
            begin
               if (wb_cyc && wb_stb)
               begin
                  psel      <= 1'b1;
                  penable   <= 1'b0;
                  bus_timer <= '0;
                  state     <= apb_bridge_pkg::ST_SETUP;
               end
            end

            apb_bridge_pkg::ST_SETUP:
            begin
               penable <= 1'b1;
               state   <= apb_bridge_pkg::ST_ACCESS;
            end

            apb_bridge_pkg::ST_ACCESS:
            begin
               if (pready)
               begin
                  psel    <= 1'b0;
                  penable <= 1'b0;
                  wb_ack  <= !pslverr;
                  wb_err  <= pslverr;
                  state   <= apb_bridge_pkg::ST_DONE;
               end
               else if (bus_timer == apb_bridge_pkg::BUS_TIMEOUT - 8'd1)
               begin
                  // No pready within the timer window, abandon the transfer
                  psel    <= 1'b0;
                  penable <= 1'b0;
                  wb_err  <= 1'b1;
                  state   <= apb_bridge_pkg::ST_DONE;
               end
               else
               begin
                  bus_timer <= bus_timer + 8'd1;
               end
            end

            // One idle cycle while the host sees the response and drops stb
            apb_bridge_pkg::ST_DONE:
            begin
               state <= apb_bridge_pkg::ST_IDLE;
            end

            default:
            begin
               state <= apb_bridge_pkg::ST_IDLE;
            end
         endcase
      end
   end

   // Request payload is captured when a new request is accepted
   always_ff @(posedge clk)
   begin
      if (state == apb_bridge_pkg::ST_IDLE && wb_cyc && wb_stb)
      begin
         pwrite <= wb_we;
         paddr  <= wb_adr;
         pwdata <= wb_dat_w;
      end
   end

   // Read data is held from the ending access cycle until the next transfer ends
   always_ff @(posedge clk)
   begin
      if (state == apb_bridge_pkg::ST_ACCESS && pready)
      begin
         wb_dat_r <= prdata;
      end
   end

   // The access phase always follows a setup phase of the same transfer
   assert property (@(posedge clk) disable iff (!reset_n)
      penable |-> psel && $past(psel))
      else $error("penable without a preceding setup phase");

   // Exactly one response, held for a single cycle
   assert property (@(posedge clk) disable iff (!reset_n)
      (wb_ack || wb_err) |-> !(wb_ack && wb_err) ##1 !(wb_ack || wb_err))
      else $error("bad Wishbone response");

endmodule

// ==== verification/apb_bridge_tb.sv ====
// --------------------------------------------------
// APB bridge subsystem testbench
// Directed Wishbone traffic against the slave row
// --------------------------------------------------

`timescale 1ns/1ns

module apb_bridge_tb;

   logic                  clk;
   logic                  reset_n;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   apb_bridge_pkg::addr_t wb_adr;
   apb_bridge_pkg::data_t wb_dat_w;
   logic                  wb_ack;
   logic                  wb_err;
   apb_bridge_pkg::data_t wb_dat_r;

   // Expected contents of every register of every slave
   apb_bridge_pkg::data_t model [apb_bridge_pkg::NUM_SLAVES][4];
   int                    error_count;
   int                    failure_count;
   int                    cycle_count;

   apb_bridge_top dut0 (
      .clk(clk), .reset_n(reset_n),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
      .wb_ack(wb_ack), .wb_err(wb_err), .wb_dat_r(wb_dat_r)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #20 clk = ~clk;
      end
   end

   // Slave index in bits 11:8, register offset in bits 3:2
   function automatic apb_bridge_pkg::addr_t make_addr(input int slave, input int offset);
      return (apb_bridge_pkg::addr_t'(slave) << 8) | (apb_bridge_pkg::addr_t'(offset) << 2);
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual)
      begin
         error_count++;
         $display("error %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic expect_response(input string name, input logic want_err, input logic got_err);
      if (want_err !== got_err)
      begin
         failure_count++;
         $display("%s: the transfer ended in %s instead of %s", name,
                  got_err ? "err" : "ack", want_err ? "err" : "ack");
      end
   endtask

   // One Wishbone classic cycle, held until ack or err and counted from the sampling edge
   task automatic wb_access(input logic we, input apb_bridge_pkg::addr_t adr,
                            input apb_bridge_pkg::data_t wdata,
                            output apb_bridge_pkg::data_t rdata,
                            output logic got_err, output int cycles);
      @(posedge clk);
      #5;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      cycles   = 0;
      do
      begin
         @(posedge clk);
         #5;
         cycles++;
      end
      while (!wb_ack && !wb_err);
      if (wb_ack && wb_err)
      begin
         failure_count++;
         $display("ack and err were high together at address %h", adr);
      end
      got_err = wb_err;
      rdata   = wb_dat_r;
      wb_cyc  = 1'b0;
      wb_stb  = 1'b0;
      wb_we   = 1'b0;
   endtask

   task automatic wb_write(input apb_bridge_pkg::addr_t adr, input apb_bridge_pkg::data_t wdata,
                           output logic got_err);
      apb_bridge_pkg::data_t unused_data;
      int                    unused_cycles;
      wb_access(1'b1, adr, wdata, unused_data, got_err, unused_cycles);
   endtask

   task automatic wb_read(input apb_bridge_pkg::addr_t adr, output apb_bridge_pkg::data_t rdata,
                          output logic got_err, output int cycles);
      wb_access(1'b0, adr, '0, rdata, got_err, cycles);
   endtask

   // Writes a register, expects ack and updates the model
   task automatic write_reg(input string name, input int slave, input int offset,
                            input apb_bridge_pkg::data_t value);
      logic got_err;
      wb_write(make_addr(slave, offset), value, got_err);
      expect_response(name, 1'b0, got_err);
      // The wait register keeps only its low byte
      model[slave][offset] = (offset == 0) ? {24'd0, value[7:0]} : value;
   endtask

   // Reads a register, expects ack and compares with the model
   task automatic verify_reg(input string name, input int slave, input int offset);
      apb_bridge_pkg::data_t rdata;
      logic                  got_err;
      int                    cycles;
      wb_read(make_addr(slave, offset), rdata, got_err, cycles);
      expect_response(name, 1'b0, got_err);
      check(name, model[slave][offset], rdata);
   endtask

   task automatic test_reset_state();
      check("reset ack", 32'd0, {31'd0, wb_ack});
      check("reset err", 32'd0, {31'd0, wb_err});
      for (int s = 0; s < apb_bridge_pkg::NUM_SLAVES; s++)
      begin
         for (int o = 0; o < 4; o++)
         begin
            verify_reg($sformatf("reset s%0d o%0d", s, o), s, o);
         end
      end
   endtask

   task automatic test_scratch_round_trip();
      for (int s = 0; s < apb_bridge_pkg::NUM_SLAVES; s++)
      begin
         for (int o = 1; o < 4; o++)
         begin
            write_reg($sformatf("scratch write s%0d o%0d", s, o), s, o, $urandom);
         end
      end
      for (int s = 0; s < apb_bridge_pkg::NUM_SLAVES; s++)
      begin
         for (int o = 1; o < 4; o++)
         begin
            verify_reg($sformatf("scratch read s%0d o%0d", s, o), s, o);
         end
      end
   endtask

   task automatic test_slave_isolation();
      for (int s = 0; s < apb_bridge_pkg::NUM_SLAVES; s++)
      begin
         write_reg("isolation write", s, 2, 32'h1111_1111 * (s + 1));
      end
      for (int s = 0; s < apb_bridge_pkg::NUM_SLAVES; s++)
      begin
         verify_reg($sformatf("isolation s%0d", s), s, 2);
      end
   endtask

   task automatic test_wait_states();
      int                    counts [3] = '{0, 3, 20};
      apb_bridge_pkg::data_t rdata;
      logic                  got_err;
      int                    cycles;
      foreach (counts[i])
      begin
         write_reg("wait write", 1, 0, counts[i]);
         verify_reg($sformatf("wait readback %0d", counts[i]), 1, 0);
         // Setup, access and the registered ack take 3 cycles, plus one per wait state
         wb_read(make_addr(1, 1), rdata, got_err, cycles);
         expect_response("wait read", 1'b0, got_err);
         check($sformatf("wait data %0d", counts[i]), model[1][1], rdata);
         check($sformatf("wait latency %0d", counts[i]), 3 + counts[i], cycles);
      end
      write_reg("wait restore", 1, 0, 0);
   endtask

   task automatic test_timeout();
      apb_bridge_pkg::data_t rdata;
      logic                  got_err;
      int                    cycles;
      write_reg("timeout wait write", 2, 0, 150);
      wb_read(make_addr(2, 3), rdata, got_err, cycles);
      expect_response("timeout read", 1'b1, got_err);
      write_reg("timeout wait clear", 2, 0, 0);
      verify_reg("timeout recovery", 2, 3);
   endtask

   task automatic test_unmapped();
      apb_bridge_pkg::data_t rdata;
      logic                  got_err;
      int                    cycles;
      for (int idx = apb_bridge_pkg::NUM_SLAVES; idx < 16; idx++)
      begin
         wb_write(make_addr(idx, 1), $urandom, got_err);
         expect_response($sformatf("unmapped write %0d", idx), 1'b1, got_err);
         wb_read(make_addr(idx, 1), rdata, got_err, cycles);
         expect_response($sformatf("unmapped read %0d", idx), 1'b1, got_err);
      end
      verify_reg("after unmapped", 0, 1);
      write_reg("after unmapped write", 0, 1, $urandom);
      verify_reg("after unmapped readback", 0, 1);
   endtask

   // Roughly 800 cycles of traffic, the longest test being the bus timeout
   initial
   begin
      cycle_count = 0;
      while (cycle_count < 4000)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: the tests did not finish within %0d clock cycles", cycle_count);
      $display("TESTS FAILED");
      $finish;
   end

   initial
   begin
      void'($urandom(7));
      error_count   = 0;
      failure_count = 0;
      reset_n       = 1'b0;
      wb_cyc        = 1'b0;
      wb_stb        = 1'b0;
      wb_we         = 1'b0;
      wb_adr        = '0;
      wb_dat_w      = '0;
      foreach (model[s, o])
      begin
         model[s][o] = '0;
      end
      repeat (5) @(posedge clk);
      #5;
      reset_n = 1'b1;

      test_reset_state();
      test_scratch_round_trip();
      test_slave_isolation();
      test_wait_states();
      test_timeout();
      test_unmapped();

      $display("errors: %0d, failures: %0d", error_count, failure_count);
      if (error_count == 0 && failure_count == 0)
      begin
         $display("TESTS PASSED");
      end
      else
      begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
